// File: hdl/corr_config.svh
/*
 * widths and depths shared by the whole correlator data path
 * memory depths are powers of two of the address widths
 */
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// adc word layout, offset binary in the low bits
`define CORR_ADC_BITS 14
`define CORR_ADC_WORD 16

// snapshot memory address bits
`define CORR_CAPTURE_ADDR 10

// correlator sums
`define CORR_ACC_WIDTH 40
`define CORR_ACC_LEN_WIDTH 16

// result memory, wraps after 2**CORR_RESULT_ADDR frames
`define CORR_RESULT_ADDR 6

`endif

// File: hdl/corr_pkg.sv
/*
 * types for the correlator data path
 * sample_t is two's complement after the offset-binary conversion
 */
`include "corr_config.svh"

package corr_pkg;

	typedef logic signed [`CORR_ADC_BITS-1:0] sample_t;
	typedef logic [`CORR_ADC_WORD-1:0] raw_word_t;

	typedef logic signed [`CORR_ACC_WIDTH-1:0] acc_t;
	typedef logic [`CORR_ACC_LEN_WIDTH-1:0] acc_len_t; // 0 behaves as 1

	typedef logic [`CORR_CAPTURE_ADDR-1:0] cap_addr_t;
	typedef logic [`CORR_RESULT_ADDR-1:0] res_addr_t;

	// snapshot fill control
	typedef enum logic [1:0] {
		cap_idle,
		cap_filling,
		cap_full
	} capture_state_e;

	// frame accumulation
	typedef enum logic {
		corr_idle,
		corr_accumulate
	} corr_state_e;

endpackage

// File: hdl/corr_if.sv
/*
 * sample and result buses inside the correlator, no handshake
 * valid on sample_if is a level, valid on corr_result_if a one-cycle pulse
 */

interface sample_if;
	corr_pkg::sample_t ch0;
	corr_pkg::sample_t ch1;
	logic valid; // sample belongs to the correlation
	logic arm;   // synchronized capture enable

	modport source (
		output ch0,
		output ch1,
		output valid,
		output arm
	);

	modport sink (
		input ch0,
		input ch1,
		input valid,
		input arm
	);
endinterface

interface corr_result_if;
	corr_pkg::acc_t aa;
	corr_pkg::acc_t bb;
	corr_pkg::acc_t ab;
	logic valid; // sums stable while high

	modport source (
		output aa,
		output bb,
		output ab,
		output valid
	);

	modport sink (
		input aa,
		input bb,
		input ab,
		input valid
	);
endinterface

// File: hdl/adc_frontend.sv
/*
 * adc words are offset binary in the low 14 bits, upper bits ignored
 * samples and valid have 1 cycle latency, arm has 3 (async enable)
 */
`include "corr_config.svh"

module adc_frontend (
	input logic data_clk_div,
	input logic reset,
	input corr_pkg::raw_word_t adc0_data,
	input corr_pkg::raw_word_t adc1_data,
	input logic enable_correlator,
	input logic enable_bram,
	sample_if.source smp
);

	logic [2:0] arm_sync;

	// offset binary to two's complement, flip the msb
	function automatic corr_pkg::sample_t to_signed(input corr_pkg::raw_word_t w);
		corr_pkg::sample_t s;
		s = {~w[`CORR_ADC_BITS-1], w[`CORR_ADC_BITS-2:0]};
		return s;
	endfunction

	always_ff @(posedge data_clk_div) begin
		smp.ch0 <= to_signed(adc0_data);
		smp.ch1 <= to_signed(adc1_data);
	end

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			smp.valid <= 1'b0;
			arm_sync <= '0;
		end else begin
			smp.valid <= enable_correlator; // same stage as the samples
			arm_sync <= {arm_sync[1:0], enable_bram};
		end
	end

	assign smp.arm = arm_sync[2];

endmodule

// File: hdl/capture_buffer.sv
/*
 * rising arm fills the whole memory once from address 0, falling arm rearms
 * read data is {ch0, ch1}, each sign-extended to 16 bits, 1 cycle after the address
 */
`include "corr_config.svh"

module capture_buffer (
	input logic data_clk_div,
	input logic reset,
	sample_if.sink smp,
	input corr_pkg::cap_addr_t cap_rd_addr,
	output logic [2*`CORR_ADC_WORD-1:0] cap_rd_data,
	output logic capture_done
);

	localparam int PAD = `CORR_ADC_WORD - `CORR_ADC_BITS;
	localparam int DEPTH = 2 ** `CORR_CAPTURE_ADDR;

	logic [2*`CORR_ADC_WORD-1:0] mem [DEPTH];
	corr_pkg::capture_state_e state;
	corr_pkg::cap_addr_t wr_addr;
	logic arm_d;
	logic arm_rise;
	logic arm_fall;
	logic wr_en;
	logic [2*`CORR_ADC_WORD-1:0] wr_data;

	assign arm_rise = smp.arm & ~arm_d;
	assign arm_fall = ~smp.arm & arm_d;
	assign wr_en = (state == corr_pkg::cap_filling);
	assign wr_data = {{PAD{smp.ch0[`CORR_ADC_BITS-1]}}, smp.ch0,
		{PAD{smp.ch1[`CORR_ADC_BITS-1]}}, smp.ch1};

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			state <= corr_pkg::cap_idle;
			wr_addr <= '0;
			arm_d <= 1'b0;
			capture_done <= 1'b0;
		end else begin
			arm_d <= smp.arm;
			if (arm_rise) begin
				state <= corr_pkg::cap_filling; // restart from 0
				wr_addr <= '0;
				capture_done <= 1'b0;
			end else if (arm_fall) begin
				state <= corr_pkg::cap_idle;
				capture_done <= 1'b0;
			end else if (state == corr_pkg::cap_filling) begin
				if (wr_addr == '1) begin
					state <= corr_pkg::cap_full;
					capture_done <= 1'b1;
				end else begin
					wr_addr <= wr_addr + 1'b1;
				end
			end
		end
	end

	// memory, no reset
	always_ff @(posedge data_clk_div) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		cap_rd_data <= mem[cap_rd_addr];
	end

	// a finished snapshot is never overwritten
	assert property (@(posedge data_clk_div) disable iff (reset)
		wr_en |-> !capture_done);

	// last address ends the fill, no wrap to 0
	assert property (@(posedge data_clk_div) disable iff (reset)
		wr_en && (wr_addr == '1) |=> !wr_en);

endmodule

// File: hdl/power_correlator.sv
/*
 * sums ch0*ch0, ch1*ch1 and ch0*ch1 over acc_len valid samples, 0 counts as 1
 * acc_len is sampled at each frame's first sample, result pulse 1 cycle after the last
 */
`include "corr_config.svh"

module power_correlator (
	input logic data_clk_div,
	input logic reset,
	sample_if.sink smp,
	input corr_pkg::acc_len_t acc_len,
	corr_result_if.source res
);

	localparam int PROD_W = 2 * `CORR_ADC_BITS;

	corr_pkg::corr_state_e state;
	corr_pkg::acc_len_t len_q;
	corr_pkg::acc_len_t len_eff;
	corr_pkg::acc_len_t cnt; // samples already in the frame
	logic signed [PROD_W-1:0] m_aa;
	logic signed [PROD_W-1:0] m_bb;
	logic signed [PROD_W-1:0] m_ab;
	corr_pkg::acc_t s_aa;
	corr_pkg::acc_t s_bb;
	corr_pkg::acc_t s_ab;
	corr_pkg::acc_t acc_aa;
	corr_pkg::acc_t acc_bb;
	corr_pkg::acc_t acc_ab;
	logic first;
	logic last;

	assign m_aa = smp.ch0 * smp.ch0;
	assign m_bb = smp.ch1 * smp.ch1;
	assign m_ab = smp.ch0 * smp.ch1;

	assign len_eff = (acc_len == '0) ? corr_pkg::acc_len_t'(1) : acc_len;
	assign first = (state == corr_pkg::corr_idle);
	assign last = first ? (len_eff == corr_pkg::acc_len_t'(1)) : (cnt == len_q - 1'b1);

	// running sums including the current sample
	assign s_aa = first ? corr_pkg::acc_t'(m_aa) : acc_aa + corr_pkg::acc_t'(m_aa);
	assign s_bb = first ? corr_pkg::acc_t'(m_bb) : acc_bb + corr_pkg::acc_t'(m_bb);
	assign s_ab = first ? corr_pkg::acc_t'(m_ab) : acc_ab + corr_pkg::acc_t'(m_ab);

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			state <= corr_pkg::corr_idle;
			cnt <= '0;
			len_q <= '0;
			res.valid <= 1'b0;
		end else begin
			res.valid <= smp.valid & last;
			if (smp.valid) begin
				if (first) begin
					len_q <= len_eff;
				end
				if (last) begin
					state <= corr_pkg::corr_idle; // next valid sample opens a new frame
					cnt <= '0;
				end else begin
					state <= corr_pkg::corr_accumulate;
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// accumulators and held result, payload only
	always_ff @(posedge data_clk_div) begin
		if (smp.valid) begin
			acc_aa <= s_aa;
			acc_bb <= s_bb;
			acc_ab <= s_ab;
			if (last) begin
				res.aa <= s_aa;
				res.bb <= s_bb;
				res.ab <= s_ab;
			end
		end
	end

	// frames longer than one sample leave a gap between pulses
	assert property (@(posedge data_clk_div) disable iff (reset)
		res.valid && (len_q > 1) |=> !res.valid || (len_q == 1));

endmodule

// File: hdl/result_store.sv
/*
 * one entry of aa, bb and ab per frame at res_count, wraps after 64 frames
 * reads return 1 cycle after the address
 */
`include "corr_config.svh"

module result_store (
	input logic data_clk_div,
	input logic reset,
	corr_result_if.sink res,
	input corr_pkg::res_addr_t res_rd_addr,
	output corr_pkg::acc_t res_rd_aa,
	output corr_pkg::acc_t res_rd_bb,
	output corr_pkg::acc_t res_rd_ab,
	output corr_pkg::res_addr_t res_count
);

	localparam int DEPTH = 2 ** `CORR_RESULT_ADDR;

	corr_pkg::acc_t [2:0] mem [DEPTH]; // {ab, bb, aa}

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			res_count <= '0;
		end else if (res.valid) begin
			res_count <= res_count + 1'b1; // natural wrap
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (res.valid) begin
			mem[res_count] <= {res.ab, res.bb, res.aa};
		end
		res_rd_aa <= mem[res_rd_addr][0];
		res_rd_bb <= mem[res_rd_addr][1];
		res_rd_ab <= mem[res_rd_addr][2];
	end

	// count moves only behind a stored frame
	assert property (@(posedge data_clk_div) disable iff (reset)
		(res_count != $past(res_count)) |-> $past(res.valid));

endmodule

// File: hdl/corr_top.sv
/*
 * single clock domain, enable_bram may be asynchronous, the rest is synchronous
 * no back-pressure, results overwrite the oldest entry after wrap
 */
`include "corr_config.svh"

module corr_top (
	input logic data_clk_div,
	input logic reset,
	input corr_pkg::raw_word_t adc0_data,
	input corr_pkg::raw_word_t adc1_data,
	input logic enable_correlator,
	input logic enable_bram,
	input corr_pkg::acc_len_t acc_len,
	input corr_pkg::cap_addr_t cap_rd_addr,
	input corr_pkg::res_addr_t res_rd_addr,
	output logic [2*`CORR_ADC_WORD-1:0] cap_rd_data,
	output logic capture_done,
	output corr_pkg::acc_t res_rd_aa,
	output corr_pkg::acc_t res_rd_bb,
	output corr_pkg::acc_t res_rd_ab,
	output corr_pkg::res_addr_t res_count
);

	sample_if smp_bus ();
	corr_result_if res_bus ();

	adc_frontend adc_frontend_inst (
		.data_clk_div(data_clk_div),
		.reset(reset),
		.adc0_data(adc0_data),
		.adc1_data(adc1_data),
		.enable_correlator(enable_correlator),
		.enable_bram(enable_bram),
		.smp(smp_bus.source)
	);

	capture_buffer capture_buffer_inst (
		.data_clk_div(data_clk_div),
		.reset(reset),
		.smp(smp_bus.sink),
		.cap_rd_addr(cap_rd_addr),
		.cap_rd_data(cap_rd_data),
		.capture_done(capture_done)
	);

	power_correlator power_correlator_inst (
		.data_clk_div(data_clk_div),
		.reset(reset),
		.smp(smp_bus.sink),
		.acc_len(acc_len),
		.res(res_bus.source)
	);

	result_store result_store_inst (
		.data_clk_div(data_clk_div),
		.reset(reset),
		.res(res_bus.sink),
		.res_rd_addr(res_rd_addr),
		.res_rd_aa(res_rd_aa),
		.res_rd_bb(res_rd_bb),
		.res_rd_ab(res_rd_ab),
		.res_count(res_count)
	);

endmodule

// File: dv/corr_tb.sv
/*
 * ramp and random adc words, results checked against a software model of the sums
 * the whole run stays below 64 frames, so result addresses never wrap
 */
`include "corr_config.svh"

module corr_tb;

	localparam int ADC_RANGE = 1 << `CORR_ADC_BITS;
	localparam int HALF_RANGE = ADC_RANGE / 2;
	localparam int W = `CORR_ADC_WORD;
	localparam int B = `CORR_ADC_BITS;
	localparam int CAP_DEPTH = 1 << `CORR_CAPTURE_ADDR;
	localparam int RES_DEPTH = 1 << `CORR_RESULT_ADDR;

	logic data_clk_div;
	logic reset;
	corr_pkg::raw_word_t adc0_data;
	corr_pkg::raw_word_t adc1_data;
	logic enable_correlator;
	logic enable_bram;
	corr_pkg::acc_len_t acc_len;
	corr_pkg::cap_addr_t cap_rd_addr;
	corr_pkg::res_addr_t res_rd_addr;
	logic [2*W-1:0] cap_rd_data;
	logic capture_done;
	corr_pkg::acc_t res_rd_aa;
	corr_pkg::acc_t res_rd_bb;
	corr_pkg::acc_t res_rd_ab;
	corr_pkg::res_addr_t res_count;

	int errors = 0;
	int checks = 0;
	int timeouts = 0;
	int unsigned lcg_state = 77;
	int req_id = 0;
	int ack_id = 0;
	int ramp_start0;
	int ramp_start1;
	int ramp_span; // words driven since enable_bram rose
	int frame_base;
	int frame_len;
	corr_pkg::raw_word_t raw0_q[$]; // words driven with enable_correlator high
	corr_pkg::raw_word_t raw1_q[$];

	corr_top corr_top_inst (
		.data_clk_div(data_clk_div),
		.reset(reset),
		.adc0_data(adc0_data),
		.adc1_data(adc1_data),
		.enable_correlator(enable_correlator),
		.enable_bram(enable_bram),
		.acc_len(acc_len),
		.cap_rd_addr(cap_rd_addr),
		.res_rd_addr(res_rd_addr),
		.cap_rd_data(cap_rd_data),
		.capture_done(capture_done),
		.res_rd_aa(res_rd_aa),
		.res_rd_bb(res_rd_bb),
		.res_rd_ab(res_rd_ab),
		.res_count(res_count)
	);

	initial begin
		data_clk_div = 1'b0;
		forever #4 data_clk_div = ~data_clk_div;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// offset binary word to signed value
	function automatic longint adc_value(input corr_pkg::raw_word_t w);
		int v;
		v = int'(w[B-1:0]) ^ HALF_RANGE;
		if (v >= HALF_RANGE) begin
			v = v - ADC_RANGE;
		end
		return longint'(v);
	endfunction

	// captured sample field back to its raw adc code
	function automatic int field_to_raw(input logic [B-1:0] f);
		return int'(f) ^ HALF_RANGE;
	endfunction

	// expected sums of one frame of the recorded valid words
	function automatic void frame_ref(input int first, input int len,
		output longint aa, output longint bb, output longint ab);
		longint s0;
		longint s1;
		aa = 0;
		bb = 0;
		ab = 0;
		for (int i = 0; i < len; i++) begin
			s0 = adc_value(raw0_q[first + i]);
			s1 = adc_value(raw1_q[first + i]);
			aa = aa + s0 * s0;
			bb = bb + s1 * s1;
			ab = ab + s0 * s1;
		end
	endfunction

	task automatic compare_value(input string name, input longint exp, input longint act);
		checks++;
		assert (exp == act) else begin
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timeout: %s", what);
		timeouts++;
	endtask

	task automatic read_result(input int addr, output longint aa, output longint bb,
		output longint ab);
		@(negedge data_clk_div);
		res_rd_addr = corr_pkg::res_addr_t'(addr);
		@(negedge data_clk_div);
		aa = longint'(res_rd_aa);
		bb = longint'(res_rd_bb);
		ab = longint'(res_rd_ab);
	endtask

	task automatic drive_ramp(input int start0, input int start1);
		int n;
		ramp_start0 = start0 % ADC_RANGE;
		ramp_start1 = start1 % ADC_RANGE;
		n = 0;
		while (!capture_done && n < CAP_DEPTH + 64) begin
			@(negedge data_clk_div);
			adc0_data = corr_pkg::raw_word_t'(start0 + n);
			adc1_data = corr_pkg::raw_word_t'(start1 - n); // counts down
			enable_bram = 1'b1;
			n++;
		end
		ramp_span = n;
		if (!capture_done) begin
			note_timeout("capture_done did not rise while the ramp was running");
		end
	endtask

	task automatic release_capture();
		int n;
		@(negedge data_clk_div);
		enable_bram = 1'b0;
		n = 0;
		while (capture_done && n < 16) begin
			@(negedge data_clk_div);
			n++;
		end
		if (capture_done) begin
			note_timeout("capture_done stayed high after enable_bram fell");
		end
	endtask

	task automatic open_phase(input int len);
		@(negedge data_clk_div);
		acc_len = corr_pkg::acc_len_t'(len);
		frame_len = (len == 0) ? 1 : len;
		frame_base = int'(res_count);
		raw0_q.delete();
		raw1_q.delete();
	endtask

	task automatic feed_samples(input int n_valid, input bit toggle);
		int got;
		int cycles;
		int unsigned r;
		bit en;
		got = 0;
		cycles = 0;
		while (got < n_valid && cycles < 8 * n_valid + 64) begin
			@(negedge data_clk_div);
			r = lcg_next();
			adc0_data = corr_pkg::raw_word_t'(r >> 16);
			r = lcg_next();
			adc1_data = corr_pkg::raw_word_t'(r >> 16);
			en = toggle ? r[27] : 1'b1;
			enable_correlator = en;
			if (en) begin
				raw0_q.push_back(adc0_data);
				raw1_q.push_back(adc1_data);
				got++;
			end
			cycles++;
		end
		@(negedge data_clk_div);
		enable_correlator = 1'b0;
		if (got < n_valid) begin
			note_timeout("enable_correlator gave too few valid samples");
		end
	endtask

	task automatic wait_results();
		int expect_count;
		int n;
		expect_count = (frame_base + raw0_q.size() / frame_len) % RES_DEPTH;
		n = 0;
		while (int'(res_count) != expect_count && n < 32) begin
			@(negedge data_clk_div);
			n++;
		end
		if (int'(res_count) != expect_count) begin
			note_timeout("res_count never reached the number of finished frames");
		end
	endtask

	task automatic request_compare(input int id);
		int n;
		req_id = id;
		n = 0;
		while (ack_id != id && n < 5000) begin
			@(negedge data_clk_div);
			n++;
		end
		if (ack_id != id) begin
			note_timeout($sformatf("compare step %0d did not finish", id));
		end
	endtask

	// steps must be +1 on adc0 and -1 on adc1, address 0 from the current ramp
	task automatic verify_capture(input string name);
		logic [W-1:0] half0;
		logic [W-1:0] half1;
		int cur0;
		int cur1;
		int prev0;
		int prev1;
		int first0;
		int first1;
		int offset;
		prev0 = 0;
		prev1 = 0;
		first0 = 0;
		first1 = 0;
		@(negedge data_clk_div);
		cap_rd_addr = '0;
		for (int a = 0; a < CAP_DEPTH; a++) begin
			@(negedge data_clk_div);
			half0 = cap_rd_data[2*W-1:W];
			half1 = cap_rd_data[W-1:0];
			cap_rd_addr = corr_pkg::cap_addr_t'(a + 1);
			compare_value($sformatf("%s addr %0d ch0 sign", name, a),
				longint'($signed(half0[B-1:0])), longint'($signed(half0)));
			compare_value($sformatf("%s addr %0d ch1 sign", name, a),
				longint'($signed(half1[B-1:0])), longint'($signed(half1)));
			cur0 = field_to_raw(half0[B-1:0]);
			cur1 = field_to_raw(half1[B-1:0]);
			if (a == 0) begin
				first0 = cur0;
				first1 = cur1;
			end else begin
				compare_value($sformatf("%s addr %0d adc0 step", name, a),
					(prev0 + 1) % ADC_RANGE, cur0);
				compare_value($sformatf("%s addr %0d adc1 step", name, a),
					(prev1 + ADC_RANGE - 1) % ADC_RANGE, cur1);
			end
			prev0 = cur0;
			prev1 = cur1;
		end
		offset = (first0 - ramp_start0 + ADC_RANGE) % ADC_RANGE;
		checks++;
		assert (offset < ramp_span) else begin
			$display("ERR %s addr 0 adc0: expected %0h to %0h, actual %0h", name,
				ramp_start0, (ramp_start0 + ramp_span - 1) % ADC_RANGE, first0);
			errors++;
		end
		compare_value({name, " addr 0 adc1"}, (ramp_start1 - offset + ADC_RANGE) % ADC_RANGE,
			first1);
	endtask

	task automatic verify_frames(input string name);
		int n_frames;
		longint aa;
		longint bb;
		longint ab;
		longint eaa;
		longint ebb;
		longint eab;
		n_frames = raw0_q.size() / frame_len;
		@(negedge data_clk_div);
		compare_value({name, " frame count"}, n_frames,
			(int'(res_count) - frame_base + RES_DEPTH) % RES_DEPTH);
		for (int f = 0; f < n_frames; f++) begin
			read_result((frame_base + f) % RES_DEPTH, aa, bb, ab);
			frame_ref(f * frame_len, frame_len, eaa, ebb, eab);
			compare_value($sformatf("%s frame %0d aa", name, f), eaa, aa);
			compare_value($sformatf("%s frame %0d bb", name, f), ebb, bb);
			compare_value($sformatf("%s frame %0d ab", name, f), eab, ab);
		end
	endtask

	// compare process, serves one request per test step
	initial begin
		int n;
		for (int k = 1; k <= 6; k++) begin
			n = 0;
			while (req_id != k && n < 40000) begin
				@(negedge data_clk_div);
				n++;
			end
			if (req_id != k) begin
				note_timeout($sformatf("compare process got no request for step %0d", k));
				break;
			end
			case (k)
				1: begin
					compare_value("reset capture_done", 0, capture_done);
					compare_value("reset res_count", 0, res_count);
				end
				2: verify_capture("ramp capture");
				3: verify_capture("refill capture");
				4: verify_frames("continuous len 8");
				5: verify_frames("gated len 8");
				default: verify_frames("len 1");
			endcase
			ack_id = k;
		end
	end

	initial begin
		reset = 1'b1;
		adc0_data = '0;
		adc1_data = '0;
		enable_correlator = 1'b0;
		enable_bram = 1'b0;
		acc_len = corr_pkg::acc_len_t'(8);
		cap_rd_addr = '0;
		res_rd_addr = '0;
		repeat (8) @(negedge data_clk_div);
		reset = 1'b0;
		request_compare(1);

		drive_ramp(32'hBF80, 32'h0040); // both channels wrap inside the window
		request_compare(2);
		release_capture();
		drive_ramp(32'h6123, 32'h1800);
		request_compare(3);

		open_phase(8);
		feed_samples(80, 1'b0);
		wait_results();
		request_compare(4);

		open_phase(8);
		feed_samples(64, 1'b1);
		wait_results();
		request_compare(5);

		open_phase(1);
		feed_samples(20, 1'b0); // back-to-back result pulses
		wait_results();
		request_compare(6);

		@(negedge data_clk_div);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hdl
hdl/corr_pkg.sv
hdl/corr_if.sv
hdl/adc_frontend.sv
hdl/capture_buffer.sv
hdl/power_correlator.sv
hdl/result_store.sv
hdl/corr_top.sv
dv/corr_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the correlator testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module corr_tb \
	-o corr_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/corr_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
